// File: flist.f
+incdir+source
source/tracePkg.sv
source/wordCapture.sv
source/replyBuilder.sv
source/traceResponder.sv
verif/traceResponder_chk.sv
verif/traceResponderTb.sv

// File: run.sh
#!/bin/sh
# Compile the trace responder testbench with Verilator and run it.
# The run passes only when the pass line shows up in the output.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f flist.f --top-module traceResponderTb \
  -Mdir obj_dir -o simv &&
simOut=$(./obj_dir/simv) ; echo "$simOut" ;
echo "$simOut" | grep -qx -- '>>> PASS' &&
echo "simulation passed" ||
{ echo "simulation failed" ; exit 1 ; }

// File: source/replyBuilder.sv
/*
  Reply side of the trace responder.
  After each received frame it sends a nine-word echo (header, instret pair,
  sequence word), drops one reply per loss interval and holds the receive
  stream off until the reply has gone out.
*/
`timescale 1ns/10ps
`include "trace_consts.svh"

module replyBuilder (
  input  logic                clk,
  input  logic                reset,
  input  logic                rxValid,
  input  logic                rxLast,
  output logic                rxReady,
  input  tracePkg::headerT    header,
  input  tracePkg::instretT   instret,
  output tracePkg::traceWordT txData,
  output logic                txValid,
  output logic                txLast,
  input  logic                txReady
);
  import tracePkg::*;

  localparam int COUNT_W   = $clog2(`TRACE_REPLY_WORDS);
  localparam int LOSS_W    = $clog2(`TRACE_LOSS_INTERVAL + 1);
  localparam int HDR_IDX_W = $clog2(`TRACE_HDR_WORDS);

  // reply slot map
  localparam logic [COUNT_W-1:0] HDR_END    = COUNT_W'(`TRACE_HDR_WORDS);
  localparam logic [COUNT_W-1:0] INSTRET_HI = COUNT_W'(`TRACE_HDR_WORDS + 1);
  localparam logic [COUNT_W-1:0] LAST_SLOT  = COUNT_W'(`TRACE_REPLY_WORDS - 1);
  localparam logic [LOSS_W-1:0]  LOSS_MAX   = LOSS_W'(`TRACE_LOSS_INTERVAL);

  typedef enum logic {stateIdle, stateSend} stateT;

  stateT              state;
  logic [COUNT_W-1:0] replyCount;  // slot of the word on txData
  logic [LOSS_W-1:0]  lossCount;   // replies since the last dropped one
  traceWordT          frameCount;  // frames completed since reset
  traceWordT          seqWord;
  logic               frameEnd;
  logic               dropReply;
  logic               txFire;

  //////////////////////////////
  // handshakes
  //////////////////////////////
  assign rxReady   = (state == stateIdle);    // no new frame while a reply is out
  assign frameEnd  = rxValid & rxReady & rxLast;
  assign dropReply = (lossCount == LOSS_MAX);
  assign txValid   = (state == stateSend);
  assign txLast    = txValid & (replyCount == LAST_SLOT);
  assign txFire    = txValid & txReady;

  // ordinal of the frame being answered
  assign seqWord = frameCount - traceWordT'(1);

  //////////////////////////////
  // idle/send FSM
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= stateIdle;
    end else begin
      case (state)
        stateIdle: if (frameEnd && !dropReply) state <= stateSend;
        stateSend: if (txFire && txLast) state <= stateIdle;
        default: state <= stateIdle;
      endcase
    end
  end

  // advances only on a transfer, so txData holds under back-pressure
  always_ff @(posedge clk) begin
    if (reset) begin
      replyCount <= '0;
    end else if (txFire) begin
      replyCount <= txLast ? '0 : replyCount + COUNT_W'(1);
    end
  end

  //////////////////////////////
  // loss and frame counters
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      lossCount  <= '0;
      frameCount <= '0;
    end else if (frameEnd) begin
      lossCount  <= dropReply ? '0 : lossCount + LOSS_W'(1);  // wrap on the dropped frame
      frameCount <= frameCount + traceWordT'(1);  // dropped frames count too
    end
  end

  //////////////////////////////
  // reply word select
  //////////////////////////////
  always_comb begin
    txData = seqWord;  // closing slot
    if (replyCount < HDR_END) begin
      txData = header[replyCount[HDR_IDX_W-1:0]];
    end else if (replyCount == HDR_END) begin
      txData = instret[0];  // low half
    end else if (replyCount == INSTRET_HI) begin
      txData = instret[1];
    end
  end

endmodule

// File: source/tracePkg.sv
/*
  Shared data types of the trace-frame responder.
  Modules import it inside their body and use scoped names in port lists.
*/
`include "trace_consts.svh"

package tracePkg;

  // one word of the receive or transmit stream
  typedef logic [`TRACE_WORD_W-1:0] traceWordT;

  // header words, element 0 is the first word received
  typedef traceWordT [`TRACE_HDR_WORDS-1:0] headerT;

  // retired-instruction count, low word arrives first
  typedef traceWordT [1:0] instretT;

  // position of a word inside its frame
  typedef logic [`TRACE_INDEX_W-1:0] wordIndexT;

endpackage

// File: source/traceResponder.sv
/*
  Top level of the trace-frame responder.
  Two captures watch the receive stream side by side, one for the header
  and one for the instret pair, and the reply builder echoes them back.
*/
`timescale 1ns/10ps
`include "trace_consts.svh"

module traceResponder (
  input  logic                clk,
  input  logic                reset,
  // receive stream
  input  tracePkg::traceWordT rxData,
  input  logic                rxValid,
  input  logic                rxLast,
  output logic                rxReady,
  // transmit stream
  output tracePkg::traceWordT txData,
  output logic                txValid,
  output logic                txLast,
  input  logic                txReady
);
  import tracePkg::*;

  headerT  header;   // words 0..5 of the last frame
  instretT instret;  // words 9 and 10

  wordCapture #(
    .payloadT   (headerT),
    .FIRST_WORD (wordIndexT'(0))
  ) headerCapture (
    .clk, .reset,
    .rxData, .rxValid, .rxReady, .rxLast,
    .payload (header)
  );

  wordCapture #(
    .payloadT   (instretT),
    .FIRST_WORD (wordIndexT'(`TRACE_INSTRET_OFFSET))
  ) instretCapture (
    .clk, .reset,
    .rxData, .rxValid, .rxReady, .rxLast,
    .payload (instret)
  );

  // owns rxReady and decides where a frame ends
  replyBuilder replyBuilder (
    .clk,
    .reset,
    .rxValid,
    .rxLast,
    .rxReady,
    .header,
    .instret,
    .txData,
    .txValid,
    .txLast,
    .txReady
  );

endmodule

// File: source/trace_consts.svh
/*
  Sizing and protocol constants for the trace-frame responder.
  Include in any file that needs the widths or the frame layout.
*/
`ifndef TRACE_CONSTS_SVH
`define TRACE_CONSTS_SVH

//////////////////////////////
// stream
//////////////////////////////
`define TRACE_WORD_W 32         // bits per stream word
`define TRACE_INDEX_W 10        // word position counter, frames up to 1024 words

//////////////////////////////
// frame layout
//////////////////////////////
`define TRACE_HDR_WORDS 6       // link header plus frame count
`define TRACE_INSTRET_OFFSET 9  // low word of the first record's instret

//////////////////////////////
// reply
//////////////////////////////
`define TRACE_REPLY_WORDS 9     // header, instret pair, sequence word
`define TRACE_LOSS_INTERVAL 10  // replies sent between two dropped ones

`endif

// File: source/wordCapture.sv
/*
  Captures a run of consecutive words from the receive stream.
  The payload type sets how many words are kept and FIRST_WORD sets
  where in the frame the run starts. Slots the frame never reaches read as zero.
*/
`timescale 1ns/10ps
`include "trace_consts.svh"

module wordCapture #(
  parameter type payloadT = tracePkg::headerT,
  parameter tracePkg::wordIndexT FIRST_WORD = '0
) (
  input  logic                clk,
  input  logic                reset,
  input  tracePkg::traceWordT rxData,
  input  logic                rxValid,
  input  logic                rxReady,
  input  logic                rxLast,
  output payloadT             payload
);
  import tracePkg::*;

  // words held, derived from the payload size
  localparam int NUM_WORDS = $bits(payloadT) / `TRACE_WORD_W;

  wordIndexT                 wordIdx;  // position of the next word in the frame
  traceWordT [NUM_WORDS-1:0] slots;
  logic                      rxAccept;

  assign rxAccept = rxValid & rxReady;

  //////////////////////////////
  // word position in frame
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      wordIdx <= '0;
    end else if (rxAccept) begin
      if (rxLast) wordIdx <= '0;   // next word opens a new frame
      else wordIdx <= wordIdx + wordIndexT'(1);
    end
  end

  //////////////////////////////
  // payload slots
  //////////////////////////////
  // first word of a frame wipes every slot it does not load itself,
  // so a short frame leaves zeros behind
  always_ff @(posedge clk) begin
    if (rxAccept) begin
      for (int i = 0; i < NUM_WORDS; i++) begin
        if (wordIdx == FIRST_WORD + wordIndexT'(i)) slots[i] <= rxData;
        else if (wordIdx == '0) slots[i] <= '0;
      end
    end
  end

  assign payload = payloadT'(slots);  // same bit count, slot 0 lands in element 0

endmodule

// File: verif/traceResponderTb.sv
/*
  Testbench for the trace-frame responder.
  Sends a table of frames back to back, models every reply word from the
  frame word pattern, and checks reply contents, flow control and frame loss.
*/
`timescale 1ns/10ps
`include "trace_consts.svh"

module traceResponderTb;
  import tracePkg::*;

  localparam int NUM_FRAMES     = 14;
  localparam int TIMEOUT_CYCLES = NUM_FRAMES * 100;
  localparam int LAST_WORD      = `TRACE_REPLY_WORDS - 1;

  //////////////////////////////
  // frame table
  //////////////////////////////
  // frames 3 and 12 are short, 5 stops before the instret high word
  // and 6 stops right on it, 10 is the dropped reply
  localparam int FRAME_LEN [NUM_FRAMES] = '{20, 20, 12, 8, 20, 10, 11,
                                            20, 16, 20, 20, 20, 8, 20};
  localparam bit STALL_TX [NUM_FRAMES]  = '{0, 0, 0, 0, 1, 0, 0,
                                            1, 0, 0, 0, 1, 1, 1};
  localparam bit REPLY_DUE [NUM_FRAMES] = '{1, 1, 1, 1, 1, 1, 1,
                                            1, 1, 1, 0, 1, 1, 1};

  logic      clk;
  logic      reset;
  traceWordT rxData;
  logic      rxValid;
  logic      rxLast;
  logic      rxReady;
  traceWordT txData;
  logic      txValid;
  logic      txLast;
  logic      txReady = 1'b0;

  integer      seed = 32'h9360;
  logic [31:0] randBits;
  int          cycleCount = 0;
  int          repliesSeen = 0;
  int          expectedReplies;
  int          rxFrames = 0;      // frames fully accepted
  int          lastFrame = 0;
  int          curFrame;
  int          replyWord = 0;     // slot of the next reply word
  int          replyFrames[$];    // frames owed a reply, oldest first
  bit          replyPending = 1'b0;
  bit          frameJustEnded = 1'b0;

  traceResponder DUT (
    .clk     (clk),
    .reset   (reset),
    .rxData  (rxData),
    .rxValid (rxValid),
    .rxLast  (rxLast),
    .rxReady (rxReady),
    .txData  (txData),
    .txValid (txValid),
    .txLast  (txLast),
    .txReady (txReady)
  );

  bind traceResponder traceResponder_chk handshakeChk (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //////////////////////////////
  // helpers
  //////////////////////////////
  task automatic stopOnFailure();
    $display(">>> FAIL");
    $fatal(1, "stopped at the first failure");
  endtask

  task automatic checkValue(input string testName, input traceWordT expected,
                            input traceWordT actual);
    if (actual !== expected) begin
      $display("MISMATCH %s expected %h actual %h", testName, expected, actual);
      stopOnFailure();
    end
  endtask

  // frame number on top, word position below
  function automatic traceWordT frameWord(input int f, input int w);
    return {f[15:0], w[15:0]};
  endfunction

  function automatic traceWordT expectedWord(input int f, input int k);
    int src;
    if (k < `TRACE_HDR_WORDS) src = k;
    else if (k < `TRACE_HDR_WORDS + 2) src = `TRACE_INSTRET_OFFSET + k - `TRACE_HDR_WORDS;
    else return traceWordT'(f);  // sequence word is the frame ordinal
    if (src < FRAME_LEN[f]) return frameWord(f, src);
    return '0;  // never carried by a short frame
  endfunction

  task automatic sendFrame(input int f);
    for (int w = 0; w < FRAME_LEN[f]; w++) begin
      rxValid <= 1'b1;
      rxData  <= frameWord(f, w);
      rxLast  <= (w == FRAME_LEN[f] - 1);
      @(posedge clk);
      while (!rxReady) @(posedge clk);  // word moves on the edge that sees rxReady
    end
  endtask

  //////////////////////////////
  // monitor and sink
  //////////////////////////////
  always @(posedge clk) begin
    if (!reset) begin
      cycleCount++;
      if (cycleCount > TIMEOUT_CYCLES) begin
        $display("timeout: run took over %0d cycles with %0d replies still open",
                 TIMEOUT_CYCLES, replyFrames.size());
        stopOnFailure();
      end
      if (replyPending) checkValue("rxReady low until txLast", '0, traceWordT'(rxReady));
      if (frameJustEnded) begin  // one cycle after the last receive word
        if (REPLY_DUE[lastFrame]) begin
          checkValue($sformatf("frame %0d reply start", lastFrame), traceWordT'(1),
                     traceWordT'(txValid));
        end else begin
          checkValue($sformatf("frame %0d dropped, txValid", lastFrame), '0,
                     traceWordT'(txValid));
          checkValue($sformatf("frame %0d dropped, rxReady", lastFrame), traceWordT'(1),
                     traceWordT'(rxReady));
        end
      end
      frameJustEnded = 1'b0;
      if (rxValid && rxReady && rxLast) begin
        frameJustEnded = 1'b1;
        lastFrame = rxFrames;
        if (REPLY_DUE[rxFrames]) begin
          replyFrames.push_back(rxFrames);
          replyPending = 1'b1;
        end
        rxFrames++;
      end
      if (txValid && txReady) begin
        if (replyFrames.size() == 0) begin
          $display("reply word sent while no frame was waiting for one");
          stopOnFailure();
        end
        curFrame = replyFrames[0];
        checkValue($sformatf("frame %0d word %0d", curFrame, replyWord),
                   expectedWord(curFrame, replyWord), txData);
        checkValue($sformatf("frame %0d word %0d txLast", curFrame, replyWord),
                   traceWordT'(replyWord == LAST_WORD), traceWordT'(txLast));
        if (replyWord == LAST_WORD) begin
          void'(replyFrames.pop_front());
          replyWord = 0;
          replyPending = 1'b0;
          repliesSeen <= repliesSeen + 1;
        end else begin
          replyWord++;
        end
      end
      // sink readiness for the next cycle
      if (replyFrames.size() != 0) begin
        if (STALL_TX[replyFrames[0]]) begin
          randBits = $random(seed);
          txReady <= randBits[0];
        end else begin
          txReady <= 1'b1;
        end
      end else begin
        txReady <= 1'b1;
      end
    end
  end

  //////////////////////////////
  // main sequence
  //////////////////////////////
  initial begin
    reset   = 1'b1;
    rxValid = 1'b0;
    rxData  = '0;
    rxLast  = 1'b0;
    expectedReplies = 0;
    for (int f = 0; f < NUM_FRAMES; f++) expectedReplies += int'(REPLY_DUE[f]);
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    checkValue("idle after reset, txValid", '0, traceWordT'(txValid));
    checkValue("idle after reset, rxReady", traceWordT'(1), traceWordT'(rxReady));
    // frames go back to back, so the next one waits on the reply
    for (int f = 0; f < NUM_FRAMES; f++) sendFrame(f);
    rxValid <= 1'b0;
    rxLast  <= 1'b0;
    while (repliesSeen < expectedReplies) @(posedge clk);
    repeat (3) @(posedge clk);
    @(negedge clk);
    // responder back to idle once the last reply is out
    if (!txValid && rxReady) begin
      $display(">>> PASS");
      $finish;
    end else begin
      $display("responder still busy after the last reply (txValid %b rxReady %b)",
               txValid, rxReady);
      stopOnFailure();
    end
  end

endmodule

// File: verif/traceResponder_chk.sv
/*
  Handshake rules for the trace responder's transmit stream and receive gating.
  The testbench binds it to the traceResponder top level.
*/
`timescale 1ns/10ps

module traceResponder_chk (
  input logic                clk,
  input logic                reset,
  input logic                rxReady,
  input tracePkg::traceWordT txData,
  input logic                txValid,
  input logic                txLast,
  input logic                txReady
);

  // offered word stays offered until it is taken
  validHold: assert property (@(posedge clk) disable iff (reset)
    txValid && !txReady |=> txValid)
    else $error("txValid dropped before txReady took the word");

  // stalled word must not change underneath the sink
  dataStable: assert property (@(posedge clk) disable iff (reset)
    txValid && !txReady |=> $stable(txData) && $stable(txLast))
    else $error("txData or txLast changed while the sink stalled");

  lastWithValid: assert property (@(posedge clk) disable iff (reset)
    txLast |-> txValid)
    else $error("txLast high without txValid");

  // receive side closed while a reply is out
  rxClosed: assert property (@(posedge clk) disable iff (reset)
    txValid |-> !rxReady)
    else $error("rxReady high while a reply word is offered");

endmodule
